/* mem_pkg.sv */
package mem_pkg;

   // funct3 codes for loads and stores
   localparam logic [2:0] f3_byte   = 3'b000; // lb / sb
   localparam logic [2:0] f3_half   = 3'b001; // lh / sh
   localparam logic [2:0] f3_word   = 3'b010; // lw / sw
   localparam logic [2:0] f3_byte_u = 3'b100; // lbu
   localparam logic [2:0] f3_half_u = 3'b101; // lhu

   // major opcodes
   localparam logic [6:0] op_load  = 7'b0000011;
   localparam logic [6:0] op_store = 7'b0100011;

   // I-type layout, used for loads
   typedef struct packed {
      logic [11:0] imm;    // offset, sign bit at top
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   // S-type layout, used for stores
   typedef struct packed {
      logic [6:0]  imm_hi; // offset [11:5]
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  imm_lo; // offset [4:0]
      logic [6:0]  opcode;
   } s_fmt_t;

   // one instruction word, two decodings
   typedef union packed {
      i_fmt_t i_fmt;
      s_fmt_t s_fmt;
   } instr_t;

   typedef struct packed {
      instr_t      instr;
      logic [31:0] rs1_val; // base address
      logic [31:0] rs2_val; // store data
   } lsu_req_t;

   // decode -> memory
   typedef struct packed {
      logic [31:0] addr;
      logic [3:0]  byte_mask;  // write lane enables
      logic [31:0] wdata;      // already on its lanes
      logic        is_store;
      logic [2:0]  funct3;
      logic        misaligned;
      logic [4:0]  rd;
   } mem_op_t;

   // memory -> alignment
   typedef struct packed {
      logic [31:0] rdata;      // full word as read
      logic [1:0]  byte_off;
      logic [2:0]  funct3;
      logic        is_store;
      logic        misaligned;
      logic [4:0]  rd;
   } mem_rsp_t;

   typedef struct packed {
      logic [31:0] data;       // extended load value, zero otherwise
      logic [4:0]  rd;
      logic        is_store;
      logic        misaligned;
   } lsu_res_t;

endpackage

/* lsu_decode.sv */
`timescale 1ns/1ns

module lsu_decode import mem_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  lsu_req_t req,
   input  logic     req_valid,
   output logic     req_ready,
   output mem_op_t  op,
   output logic     op_valid,
   input  logic     op_ready
);

   logic        is_store;   // S-type view selected
   logic [2:0]  funct3;
   logic [31:0] offset;     // sign-extended immediate
   logic [31:0] addr;       // effective address
   logic [1:0]  byte_off;
   logic [3:0]  mask;
   logic [31:0] wdata;
   logic        misaligned;
   logic [4:0]  rd;
   mem_op_t     op_next;
   logic        accept;

   // anything that is not a store is taken as a load
   assign is_store = req.instr.s_fmt.opcode == op_store;
   assign funct3   = req.instr.i_fmt.funct3;  // same bits in both layouts

   always_comb begin
      if (is_store) begin
         offset = {{20{req.instr.s_fmt.imm_hi[6]}},
                   req.instr.s_fmt.imm_hi, req.instr.s_fmt.imm_lo};
      end else begin
         offset = {{20{req.instr.i_fmt.imm[11]}}, req.instr.i_fmt.imm};
      end
   end

   assign addr     = req.rs1_val + offset;
   assign byte_off = addr[1:0];
   assign rd       = is_store ? 5'd0 : req.instr.i_fmt.rd; // stores write no register

   // lane mask and store data placement
   always_comb begin
      mask       = 4'b0000;
      wdata      = req.rs2_val;
      misaligned = 1'b0;
      case (funct3)
         f3_byte, f3_byte_u: begin
            mask  = 4'b0001 << byte_off;                         // any offset is fine
            wdata = {24'd0, req.rs2_val[7:0]} << {byte_off, 3'b000};
         end
         f3_half, f3_half_u: begin
            wdata = {16'd0, req.rs2_val[15:0]} << {byte_off, 3'b000};
            if (byte_off[0]) begin
               misaligned = 1'b1;                               // odd offset
            end else if (byte_off[1]) begin
               mask = 4'b1100;                                  // upper half
            end else begin
               mask = 4'b0011;                                  // lower half
            end
         end
         default: begin                                         // word and unused codes
            if (byte_off != 2'b00) begin
               misaligned = 1'b1;
            end else begin
               mask = 4'b1111;
            end
         end
      endcase
   end

   always_comb begin
      op_next            = '0;
      op_next.addr       = addr;
      op_next.byte_mask  = mask;                                 // zero when misaligned
      op_next.wdata      = wdata;
      op_next.is_store   = is_store;
      op_next.funct3     = funct3;
      op_next.misaligned = misaligned;
      op_next.rd         = rd;
   end

   // skid-free stage register, takes a new item when empty or draining
   assign req_ready = !op_valid || op_ready;
   assign accept    = req_valid && req_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         op_valid <= 1'b0;
      end else if (req_ready) begin
         op_valid <= req_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         op <= op_next;                                         // payload, no reset
      end
   end

endmodule

/* data_mem.sv */
`timescale 1ns/1ns

module data_mem import mem_pkg::*; #(
   parameter int addr_bits = 10           // word address width
) (
   input  logic        clk,
   input  logic        rst,
   input  mem_op_t     op,
   input  logic        op_valid,
   output logic        op_ready,
   output mem_rsp_t    rsp,
   output logic        rsp_valid,
   input  logic        rsp_ready,
   input  logic [31:0] pc,
   output logic [31:0] instruction
);

   localparam int words = 2 ** addr_bits;

   logic [3:0][7:0]      mem [words];      // four byte lanes per word
   logic [addr_bits-1:0] waddr;            // data word index
   logic [addr_bits-1:0] faddr;            // fetch word index
   logic                 accept;
   logic                 do_write;

   assign waddr = op.addr[addr_bits+1:2];  // upper address bits wrap
   assign faddr = pc[addr_bits+1:2];       // low pc bits ignored

   // fetch port, combinational
   assign instruction = mem[faddr];

   assign op_ready = !rsp_valid || rsp_ready;
   assign accept   = op_valid && op_ready;
   assign do_write = accept && op.is_store && !op.misaligned; // misaligned store is dropped

   // array write, lane by lane
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int w = 0; w < words; w++) begin
            mem[w] <= '0;                     // whole array zeroed
         end
      end else if (do_write) begin
         for (int b = 0; b < 4; b++) begin
            if (op.byte_mask[b]) begin
               mem[waddr][b] <= op.wdata[8*b +: 8]; // only enabled lanes
            end
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rsp_valid <= 1'b0;
      end else if (op_ready) begin
         rsp_valid <= op_valid;
      end
   end

   // response payload captured with the write
   always_ff @(posedge clk) begin
      if (accept) begin
         rsp.rdata      <= mem[waddr];         // value before this edge's write
         rsp.byte_off   <= op.addr[1:0];
         rsp.funct3     <= op.funct3;
         rsp.is_store   <= op.is_store;
         rsp.misaligned <= op.misaligned;
         rsp.rd         <= op.rd;
      end
   end

endmodule

/* load_align.sv */
`timescale 1ns/1ns

module load_align import mem_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  mem_rsp_t rsp,
   input  logic     rsp_valid,
   output logic     rsp_ready,
   output lsu_res_t res,
   output logic     res_valid,
   input  logic     res_ready
);

   logic [31:0] shifted;   // addressed byte moved to bit 0
   logic [31:0] data;
   lsu_res_t    res_next;
   logic        accept;

   assign shifted = rsp.rdata >> {rsp.byte_off, 3'b000};

   // size select and extension
   always_comb begin
      case (rsp.funct3)
         f3_byte:   data = {{24{shifted[7]}}, shifted[7:0]};    // lb
         f3_half:   data = {{16{shifted[15]}}, shifted[15:0]};  // lh
         f3_byte_u: data = {24'd0, shifted[7:0]};               // lbu
         f3_half_u: data = {16'd0, shifted[15:0]};              // lhu
         default:   data = shifted;                             // lw, offset is zero here
      endcase
      if (rsp.is_store || rsp.misaligned) begin
         data = '0;                                             // nothing to return
      end
   end

   always_comb begin
      res_next            = '0;
      res_next.data       = data;
      res_next.rd         = rsp.rd;
      res_next.is_store   = rsp.is_store;
      res_next.misaligned = rsp.misaligned;
   end

   assign rsp_ready = !res_valid || res_ready;
   assign accept    = rsp_valid && rsp_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         res_valid <= 1'b0;
      end else if (rsp_ready) begin
         res_valid <= rsp_valid;
      end
   end

   // result held while the consumer stalls
   always_ff @(posedge clk) begin
      if (accept) begin
         res <= res_next;
      end
   end

endmodule

/* lsu_top.sv */
`timescale 1ns/1ns

module lsu_top import mem_pkg::*; #(
   parameter int addr_bits = 10        // passed to the memory
) (
   input  logic        clk,
   input  logic        rst,
   input  lsu_req_t    req,
   input  logic        req_valid,
   output logic        req_ready,
   output lsu_res_t    res,
   output logic        res_valid,
   input  logic        res_ready,
   input  logic [31:0] pc,
   output logic [31:0] instruction
);

   mem_op_t  op;                       // decode -> memory
   logic     op_valid;
   logic     op_ready;
   mem_rsp_t rsp;                      // memory -> alignment
   logic     rsp_valid;
   logic     rsp_ready;

   // stage 1, address and lanes
   lsu_decode decode_i (
      .clk       (clk),
      .rst       (rst),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .op        (op),
      .op_valid  (op_valid),
      .op_ready  (op_ready)
   );

   // stage 2, array access plus fetch
   data_mem #(
      .addr_bits (addr_bits)
   ) mem_i (
      .clk         (clk),
      .rst         (rst),
      .op          (op),
      .op_valid    (op_valid),
      .op_ready    (op_ready),
      .rsp         (rsp),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .pc          (pc),
      .instruction (instruction)
   );

   // stage 3, extraction and extension
   load_align align_i (
      .clk       (clk),
      .rst       (rst),
      .rsp       (rsp),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .res       (res),
      .res_valid (res_valid),
      .res_ready (res_ready)
   );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;          // 10 ns period
   end

   initial begin
      rst = 1'b1;
      repeat (2) @(negedge clk);      // two rising edges in reset
      rst = 1'b0;
   end

endmodule

/* tb_lsu.sv */
`timescale 1ns/1ns

module tb_lsu import mem_pkg::*; ();

   localparam int addr_bits   = 10;
   localparam int mem_bytes   = 4 * (2 ** addr_bits);
   localparam int num_reqs    = 1 + 20 * 2 + 6 * 16 + 4 * 6 + 60; // per phase
   localparam int max_stall   = 400;                     // random res_ready bursts
   localparam int cycle_limit = num_reqs * 3 + max_stall + 200;

   logic        clk;
   logic        rst;
   lsu_req_t    req;
   logic        req_valid;
   logic        req_ready;
   lsu_res_t    res;
   logic        res_valid;
   logic        res_ready;
   logic [31:0] pc;
   logic [31:0] instruction;

   logic [7:0]  shadow [mem_bytes];                      // byte model of the array
   lsu_res_t    exp_q [$];
   int          acc_q [$];                               // accept cycle per request
   bit          lat_q [$];                               // latency checked for it
   int          errors;
   int          cycle;
   bit          bp_random;
   int          stall_left;
   lsu_res_t    prev_res;
   bit          prev_stall;

   tb_clock_gen clk_gen_i (.clk(clk), .rst(rst));

   lsu_top #(.addr_bits(addr_bits)) dut_i (
      .clk(clk), .rst(rst), .req(req), .req_valid(req_valid), .req_ready(req_ready),
      .res(res), .res_valid(res_valid), .res_ready(res_ready),
      .pc(pc), .instruction(instruction)
   );

   task automatic check_val(string name, logic [31:0] expv, logic [31:0] got);
      assert (got === expv) else begin
         errors++;
         $display("Fail at %0t: %s expected %h got %h", $time, name, expv, got);
      end
   endtask

   task automatic complain(string what);
      errors++;
      $display("Error at %0t: %s", $time, what);
   endtask

   // expected result from raw instruction bits, shadow updated in order
   task automatic model_accept(lsu_req_t r);
      logic [31:0] w;
      logic        st;
      logic [2:0]  f3;
      logic [11:0] imm;
      logic [31:0] addr;
      logic [31:0] v;
      int          nbytes;
      int          base;
      logic        mis;
      lsu_res_t    e;
      w      = r.instr;
      st     = w[6:0] == 7'b0100011;
      f3     = w[14:12];
      imm    = st ? {w[31:25], w[11:7]} : w[31:20];
      addr   = r.rs1_val + {{20{imm[11]}}, imm};
      nbytes = (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
      mis    = (nbytes == 2 && addr[0]) || (nbytes == 4 && addr[1:0] != 2'b00);
      base   = int'(addr[addr_bits+1:0]);
      e      = '0;
      e.is_store   = st;
      e.misaligned = mis;
      e.rd         = st ? 5'd0 : w[11:7];
      if (st && !mis) begin
         for (int b = 0; b < nbytes; b++) shadow[base + b] = r.rs2_val[8*b +: 8];
      end else if (!st && !mis) begin
         v = '0;
         for (int b = 0; b < nbytes; b++) v[8*b +: 8] = shadow[base + b];
         if (!f3[2] && nbytes == 1) v = {{24{v[7]}}, v[7:0]};       // lb
         if (!f3[2] && nbytes == 2) v = {{16{v[15]}}, v[15:0]};     // lh
         e.data = v;
      end
      exp_q.push_back(e);
   endtask

   // result checks at each rising edge
   always @(posedge clk) begin : monitor
      lsu_res_t e;
      int       acc;
      bit       lat;
      if (!rst) begin
         cycle++;
         if (res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
               complain("result arrived with no request outstanding");
            end else begin
               e   = exp_q.pop_front();
               acc = acc_q.pop_front();
               lat = lat_q.pop_front();
               check_val("res.data", e.data, res.data);
               check_val("res.rd", 32'(e.rd), 32'(res.rd));
               check_val("res.is_store", 32'(e.is_store), 32'(res.is_store));
               check_val("res.misaligned", 32'(e.misaligned), 32'(res.misaligned));
               if (lat) check_val("latency", 32'd3, 32'(cycle - acc));
            end
         end
         if (req_valid && req_ready) begin
            model_accept(req);
            acc_q.push_back(cycle);
            lat_q.push_back(!bp_random);
         end
         if (prev_stall) begin
            assert (res_valid && res === prev_res) else
               complain("res changed or dropped while stalled by res_ready");
         end
         prev_stall = res_valid && !res_ready;
         prev_res   = res;
      end
   end

   // res_ready in random low bursts
   always @(negedge clk) begin
      if (!bp_random) begin
         res_ready = 1'b1;
      end else if (stall_left > 0) begin
         stall_left--;
         res_ready = 1'b0;
      end else if ($urandom % 4 == 0) begin
         stall_left = $urandom % 4;                     // burst of 1 to 4
         res_ready  = 1'b0;
      end else begin
         res_ready = 1'b1;
      end
   end

   function automatic lsu_req_t load_req(logic [2:0] f3, logic [4:0] rd,
                                         logic [31:0] base, logic [11:0] imm);
      lsu_req_t r;
      r         = '0;
      r.instr   = {imm, 5'd1, f3, rd, op_load};
      r.rs1_val = base;
      return r;
   endfunction

   function automatic lsu_req_t store_req(logic [2:0] f3, logic [31:0] base,
                                          logic [11:0] imm, logic [31:0] data);
      lsu_req_t r;
      r         = '0;
      r.instr   = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], op_store};
      r.rs1_val = base;
      r.rs2_val = data;
      return r;
   endfunction

   // called at a falling edge, returns at the falling edge after acceptance
   task automatic send(lsu_req_t r);
      req       = r;
      req_valid = 1'b1;
      do @(posedge clk); while (!req_ready);
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   task automatic drain();
      while (exp_q.size() != 0) @(negedge clk);
      repeat (2) @(negedge clk);                        // last write settled
   endtask

   task automatic check_fetch(int word);
      logic [31:0] w;
      pc = {20'd0, word[addr_bits-1:0], 2'($urandom)};  // low bits ignored
      #1;
      for (int b = 0; b < 4; b++) w[8*b +: 8] = shadow[4*word + b];
      check_val("instruction", w, instruction);
   endtask

   initial begin : timeout
      wait (cycle >= cycle_limit);
      $display("Timeout: run stopped after %0d cycles", cycle);
      $display("Error count: %0d", errors);
      $display("Finished with errors");
      $finish;
   end

   initial begin : stimulus
      logic [2:0]  f3s [5];
      logic [31:0] a;
      int          word;
      void'($urandom(32'h4d61_1a4d));
      f3s = '{f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u};
      for (int i = 0; i < mem_bytes; i++) shadow[i] = 8'h00;
      req        = '0;
      req_valid  = 1'b0;
      res_ready  = 1'b1;
      pc         = '0;
      errors     = 0;
      cycle      = 0;
      bp_random  = 1'b0;
      stall_left = 0;
      prev_stall = 1'b0;
      wait (!rst);
      @(negedge clk);
      // state right after reset
      assert (!res_valid && req_ready) else complain("valid or ready wrong after reset");
      check_fetch($urandom % 1024);
      send(load_req(f3_word, 5'd3, $urandom & 32'hffc, 12'd0));
      drain();
      // word round trips, back to back so latency is exact
      repeat (20) begin
         a = $urandom & 32'hffc;
         send(store_req(f3_word, a, 12'd0, $urandom));
         send(load_req(f3_word, 5'($urandom), a - 32'd8, 12'd8));
      end
      drain();
      // byte and halfword lanes over a random background word
      repeat (6) begin
         word = $urandom % 1024;
         a    = 32'(word) << 2;
         send(store_req(f3_word, a, 12'd0, $urandom));
         send(store_req(f3_byte, a, 12'(2'($urandom)), $urandom));
         send(store_req(f3_byte, a, 12'(2'($urandom)), $urandom));
         send(store_req(f3_half, a + 32'd4, 12'hffc + 12'(2 * ($urandom % 2)), $urandom));
         for (int o = 0; o < 4; o++) begin
            send(load_req(f3_byte, 5'd4, a, 12'(o)));
            send(load_req(f3_byte_u, 5'd5, a, 12'(o)));
         end
         for (int o = 0; o < 4; o += 2) begin
            send(load_req(f3_half, 5'd6, a, 12'(o)));
            send(load_req(f3_half_u, 5'd7, a, 12'(o)));
         end
         drain();
         check_fetch(word);
      end
      // misaligned accesses write nothing
      repeat (4) begin
         a = $urandom & 32'hffc;
         send(store_req(f3_word, a, 12'd0, $urandom));
         send(store_req(f3_half, a, 12'(1 + 2 * ($urandom % 2)), $urandom));
         send(store_req(f3_word, a, 12'(1 + $urandom % 3), $urandom));
         send(load_req(f3_half, 5'd8, a, 12'd3));
         send(load_req(f3_word, 5'd9, a, 12'd2));
         send(load_req(f3_word, 5'd10, a, 12'd0));
      end
      drain();
      // random mix under back-pressure, small region for reuse
      bp_random = 1'b1;
      repeat (60) begin
         a = 32'h100 + ($urandom % 64);
         if ($urandom % 2 == 0) send(store_req(f3s[$urandom % 3], a, 12'd0, $urandom));
         else send(load_req(f3s[$urandom % 5], 5'($urandom), a, 12'd0));
      end
      drain();
      bp_random = 1'b0;
      for (int k = 64; k < 80; k++) check_fetch(k);
      $display("Error count: %0d", errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

/* filelist.f */
mem_pkg.sv
lsu_decode.sv
data_mem.sv
load_align.sv
lsu_top.sv
tb_clock_gen.sv
tb_lsu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module tb_lsu \
   -o sim_lsu \
   && ./obj_dir/sim_lsu | tee /dev/stderr | grep -qx "Finished with no errors" \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }
